// File: Bender.yml
package:
  name: packet_sniffer

sources:
  - include_dirs:
      - source
    files:
      - source/sniffer_pkg.sv
      - source/axis_if.sv
      - source/packet_classifier.sv
      - source/packet_filter.sv
      - source/axis_reg_slice.sv
      - source/packet_sniffer.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - sim/sniffer_clk_gen.sv
      - sim/sniffer_props.sv
      - sim/tb_packet_sniffer.sv

// File: compile.f
+incdir+source
source/sniffer_pkg.sv
source/axis_if.sv
source/packet_classifier.sv
source/packet_filter.sv
source/axis_reg_slice.sv
source/packet_sniffer.sv
sim/sniffer_clk_gen.sv
sim/sniffer_props.sv
sim/tb_packet_sniffer.sv

// File: sim/sniffer_clk_gen.sv
`timescale 1ns/1ps

module sniffer_clk_gen (
  output logic nclk,
  output logic nresetn_r
);

  // 20 ns period, first rising edge at 10 ns
  initial begin
    nclk = 1'b0;
    forever #10 nclk = ~nclk;
  end

  // Reset low for 10 cycles, released just after an edge
  initial begin
    nresetn_r = 1'b0;
    repeat (10) @(posedge nclk);
    #2 nresetn_r = 1'b1;
  end

endmodule

// File: sim/sniffer_props.sv
`timescale 1ns/1ps

module sniffer_props import sniffer_pkg::*; (
  input logic      nclk,
  input logic      nresetn_r,
  // Filtered output of one direction
  input net_data_t filt_tdata,
  input net_keep_t filt_tkeep,
  input logic      filt_tlast,
  input logic      filt_tvalid,
  input logic      filt_tready,
  // Pass ready and input ready of the same direction
  input logic      pass_tready,
  input logic      in_tready
);

  // Failures so far, watched from the testbench
  int err_count = 0;

  // Stalled beat stays offered and unchanged
  a_filt_hold: assert property (@(posedge nclk) disable iff (!nresetn_r)
    filt_tvalid && !filt_tready |=> filt_tvalid && $stable(filt_tdata) &&
      $stable(filt_tkeep) && $stable(filt_tlast))
    else begin
      err_count++;
      $error("filtered beat dropped or changed while stalled");
    end

  // Empty beats never leave the slice
  a_filt_keep: assert property (@(posedge nclk) disable iff (!nresetn_r)
    filt_tvalid |-> (filt_tkeep != '0))
    else begin
      err_count++;
      $error("filtered beat with all keep bits low");
    end

  // Input stalls only behind a held filtered beat
  a_in_stall: assert property (@(posedge nclk) disable iff (!nresetn_r)
    pass_tready && !in_tready |-> filt_tvalid)
    else begin
      err_count++;
      $error("input stalled with no filtered beat held");
    end

endmodule

// File: sim/tb_packet_sniffer.sv
`timescale 1ns/1ps
`include "sniffer_settings.svh"

module tb_packet_sniffer import sniffer_pkg::*; ();

  typedef struct packed {
    net_data_t d;
    net_keep_t k;
    logic      l;
  } beat_t;

  // Traffic takes well under 2000 cycles even with stalls
  localparam int MAX_CYCLES = 4000;

  logic        nclk;
  logic        nresetn_r;
  logic        cfg_valid;
  filter_cfg_t cfg_data;
  // Index 0 is RX, 1 is TX
  net_data_t   in_d [2];
  net_keep_t   in_k [2];
  logic        in_l [2];
  logic        in_v [2];
  logic        in_r [2];
  net_data_t   pass_d [2];
  net_keep_t   pass_k [2];
  logic        pass_l [2];
  logic        pass_v [2];
  logic        pass_r [2];
  net_data_t   filt_d [2];
  net_keep_t   filt_k [2];
  logic        filt_l [2];
  logic        filt_v [2];
  logic        filt_r [2];
  // Reference model state
  filter_cfg_t cfg_now;
  beat_t       exp_pass [2][$];
  beat_t       exp_filt [2][$];
  logic        stall_en;
  int          seed = 32'hfd27;
  int          cycles = 0;

  sniffer_clk_gen u_clk_gen (.nclk(nclk), .nresetn_r(nresetn_r));

  packet_sniffer DUT (
    .nclk(nclk), .nresetn_r(nresetn_r), .cfg_valid(cfg_valid), .cfg_data(cfg_data),
    .rx_tdata(in_d[0]), .rx_tkeep(in_k[0]), .rx_tlast(in_l[0]),
    .rx_tvalid(in_v[0]), .rx_tready(in_r[0]),
    .rx_pass_tdata(pass_d[0]), .rx_pass_tkeep(pass_k[0]), .rx_pass_tlast(pass_l[0]),
    .rx_pass_tvalid(pass_v[0]), .rx_pass_tready(pass_r[0]),
    .rx_filt_tdata(filt_d[0]), .rx_filt_tkeep(filt_k[0]), .rx_filt_tlast(filt_l[0]),
    .rx_filt_tvalid(filt_v[0]), .rx_filt_tready(filt_r[0]),
    .tx_tdata(in_d[1]), .tx_tkeep(in_k[1]), .tx_tlast(in_l[1]),
    .tx_tvalid(in_v[1]), .tx_tready(in_r[1]),
    .tx_pass_tdata(pass_d[1]), .tx_pass_tkeep(pass_k[1]), .tx_pass_tlast(pass_l[1]),
    .tx_pass_tvalid(pass_v[1]), .tx_pass_tready(pass_r[1]),
    .tx_filt_tdata(filt_d[1]), .tx_filt_tkeep(filt_k[1]), .tx_filt_tlast(filt_l[1]),
    .tx_filt_tvalid(filt_v[1]), .tx_filt_tready(filt_r[1])
  );

  bind packet_sniffer sniffer_props u_rx_props (
    .nclk(nclk), .nresetn_r(nresetn_r),
    .filt_tdata(rx_filt_tdata), .filt_tkeep(rx_filt_tkeep), .filt_tlast(rx_filt_tlast),
    .filt_tvalid(rx_filt_tvalid), .filt_tready(rx_filt_tready),
    .pass_tready(rx_pass_tready), .in_tready(rx_tready)
  );

  bind packet_sniffer sniffer_props u_tx_props (
    .nclk(nclk), .nresetn_r(nresetn_r),
    .filt_tdata(tx_filt_tdata), .filt_tkeep(tx_filt_tkeep), .filt_tlast(tx_filt_tlast),
    .filt_tvalid(tx_filt_tvalid), .filt_tready(tx_filt_tready),
    .pass_tready(tx_pass_tready), .in_tready(tx_tready)
  );

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic compare_beat(input string what, input net_data_t got_d, input net_data_t exp_d,
                              input net_keep_t got_k, input net_keep_t exp_k,
                              input logic got_l, input logic exp_l);
    if (got_d !== exp_d || got_k !== exp_k || got_l !== exp_l) begin
      stop_run($sformatf("mismatch at %0d ns: %s keep %h last %b, expected keep %h last %b, %s",
                         $time, what, got_k, got_l, exp_k, exp_l,
                         (got_d === exp_d) ? "data equal" : "data differs"));
    end
  endtask

  task automatic compare_class(input string what, input pkt_class_e got, input pkt_class_e exp);
    if (got !== exp) begin
      stop_run($sformatf("mismatch at %0d ns: %s class %s, expected %s",
                         $time, what, got.name(), exp.name()));
    end
  endtask

  function automatic filter_cfg_t cfg_bit(input int pos);
    return filter_cfg_t'(1) << pos;
  endfunction

  // Drop has priority, IPv4 family bit covers UDP and TCP
  function automatic filter_action_e action_for(input pkt_class_e cls, input filter_cfg_t c);
    logic drop;
    logic trim;
    drop = 1'b0;
    trim = 1'b0;
    case (cls)
      PKT_ARP:  drop = c[`CFG_DROP_ARP];
      PKT_IPV6: drop = c[`CFG_DROP_IPV6];
      PKT_IPV4: drop = c[`CFG_DROP_IPV4];
      PKT_UDP4: begin
        drop = c[`CFG_DROP_IPV4] | c[`CFG_DROP_UDP4];
        trim = c[`CFG_TRIM_UDP4];
      end
      PKT_TCP4: begin
        drop = c[`CFG_DROP_IPV4] | c[`CFG_DROP_TCP4];
        trim = c[`CFG_TRIM_TCP4];
      end
      default: drop = 1'b0;
    endcase
    if (drop) begin
      return ACT_DROP;
    end
    return trim ? ACT_TRIM : ACT_FORWARD;
  endfunction

  // Low lanes of the trimmed header
  function automatic net_keep_t hdr_keep(input pkt_class_e cls);
    net_keep_t k;
    for (int i = 0; i < `NET_KEEP_BITS; i++) begin
      k[i] = (i < ((cls == PKT_UDP4) ? `HDR_LEN_UDP4 : `HDR_LEN_TCP4));
    end
    return k;
  endfunction

  // Random payload with the class's ethertype and protocol bytes
  function automatic net_data_t make_beat(input pkt_class_e cls, input logic first);
    net_data_t   d;
    logic [15:0] et;
    logic [7:0]  proto;
    for (int i = 0; i < `NET_DATA_BITS / 32; i++) begin
      d[32*i +: 32] = $random(seed);
    end
    et    = 16'h88b5;
    proto = 8'h01;
    case (cls)
      PKT_ARP:  et = `ETH_TYPE_ARP;
      PKT_IPV6: et = `ETH_TYPE_IPV6;
      PKT_IPV4: et = `ETH_TYPE_IPV4;
      PKT_UDP4: begin
        et    = `ETH_TYPE_IPV4;
        proto = `IP_PROTO_UDP;
      end
      PKT_TCP4: begin
        et    = `ETH_TYPE_IPV4;
        proto = `IP_PROTO_TCP;
      end
      default: et = 16'h88b5;
    endcase
    if (first) begin
      d[`ETH_TYPE_BYTE*8 +: 8]     = et[15:8];
      d[(`ETH_TYPE_BYTE+1)*8 +: 8] = et[7:0];
      d[`IP_PROTO_BYTE*8 +: 8]     = proto;
    end
    return d;
  endfunction

  // Called 2 ns after an edge, returns at the same point
  task automatic set_cfg(input filter_cfg_t value);
    cfg_valid = 1'b1;
    cfg_data  = value;
    @(posedge nclk);
    #2;
    cfg_valid = 1'b0;
    cfg_now   = value;
  endtask

  // Drives one packet and queues what each port should carry
  task automatic send_pkt(input int dir, input pkt_class_e cls, input int nbeats);
    filter_action_e act;
    pkt_class_e     dut_cls;
    logic           last;
    act = action_for(cls, cfg_now);
    for (int b = 0; b < nbeats; b++) begin
      last      = (b == nbeats - 1);
      in_d[dir] = make_beat(cls, b == 0);
      in_k[dir] = last ? ('1 >> ($unsigned($random(seed)) % 64)) : '1;
      in_l[dir] = last;
      in_v[dir] = 1'b1;
      exp_pass[dir].push_back('{in_d[dir], in_k[dir], last});
      if (act == ACT_FORWARD) begin
        exp_filt[dir].push_back('{in_d[dir], in_k[dir], last});
      end else if (act == ACT_TRIM && b == 0) begin
        exp_filt[dir].push_back('{in_d[dir], hdr_keep(cls), 1'b1});
      end
      @(negedge nclk);
      if (b == 0) begin
        dut_cls = (dir == 0) ? DUT.u_rx_filter.pkt_class : DUT.u_tx_filter.pkt_class;
        compare_class($sformatf("first beat dir %0d", dir), dut_cls, cls);
      end
      // Ready is settled mid cycle
      while (!in_r[dir]) begin
        @(negedge nclk);
      end
      @(posedge nclk);
      #2;
    end
    in_v[dir] = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_pass[0].size() + exp_pass[1].size() + exp_filt[0].size() +
           exp_filt[1].size() != 0) begin
      @(negedge nclk);
    end
    @(posedge nclk);
    #2;
  endtask

  task automatic test_defaults();
    if (pass_v[0] | pass_v[1] | filt_v[0] | filt_v[1]) begin
      stop_run("An output valid was high right after reset");
    end
    for (int c = 0; c < 6; c++) begin
      send_pkt(0, pkt_class_e'(c), 3);
      send_pkt(1, pkt_class_e'(c), 3);
    end
    wait_drain();
  endtask

  task automatic test_drop();
    int bits [3] = '{`CFG_DROP_ARP, `CFG_DROP_IPV6, `CFG_DROP_IPV4};
    foreach (bits[i]) begin
      set_cfg(cfg_bit(bits[i]));
      for (int c = 0; c < 6; c++) begin
        send_pkt(i % 2, pkt_class_e'(c), 2);
        send_pkt(i % 2, PKT_OTHER, 2);
      end
    end
    wait_drain();
  endtask

  task automatic test_trim();
    set_cfg(cfg_bit(`CFG_TRIM_UDP4) | cfg_bit(`CFG_TRIM_TCP4));
    send_pkt(0, PKT_UDP4, 4);
    send_pkt(0, PKT_TCP4, 4);
    send_pkt(1, PKT_TCP4, 1);
    send_pkt(1, PKT_IPV4, 2);
    // Drop wins when both bits are set
    set_cfg(cfg_now | cfg_bit(`CFG_DROP_UDP4) | cfg_bit(`CFG_DROP_TCP4));
    send_pkt(0, PKT_UDP4, 3);
    send_pkt(1, PKT_TCP4, 3);
    send_pkt(1, PKT_UDP4, 2);
    wait_drain();
  endtask

  task automatic test_stall();
    stall_en = 1'b1;
    set_cfg('0);
    for (int p = 0; p < 12; p++) begin
      send_pkt(p % 2, pkt_class_e'($unsigned($random(seed)) % 6),
               1 + $unsigned($random(seed)) % 4);
    end
    wait_drain();
    stall_en = 1'b0;
  endtask

  task automatic test_both_dirs();
    pkt_class_e rx_mix [6] = '{PKT_ARP, PKT_TCP4, PKT_OTHER, PKT_UDP4, PKT_IPV6, PKT_TCP4};
    pkt_class_e tx_mix [5] = '{PKT_IPV4, PKT_UDP4, PKT_TCP4, PKT_ARP, PKT_OTHER};
    stall_en = 1'b1;
    set_cfg(cfg_bit(`CFG_DROP_ARP) | cfg_bit(`CFG_TRIM_TCP4) | cfg_bit(`CFG_DROP_UDP4));
    fork
      foreach (rx_mix[i]) send_pkt(0, rx_mix[i], 3);
      foreach (tx_mix[i]) send_pkt(1, tx_mix[i], 2 + i % 2);
    join
    wait_drain();
    stall_en = 1'b0;
  endtask

  // Output checkers, a transfer completes at the next rising edge
  for (genvar g = 0; g < 2; g++) begin : g_mon
    always @(negedge nclk) begin
      beat_t e;
      if (pass_v[g] && pass_r[g]) begin
        if (exp_pass[g].size() == 0) begin
          stop_run($sformatf("mismatch at %0d ns: extra pass beat dir %0d", $time, g));
        end else begin
          e = exp_pass[g].pop_front();
          compare_beat($sformatf("pass dir %0d", g), pass_d[g], e.d, pass_k[g], e.k,
                       pass_l[g], e.l);
        end
      end
      if (filt_v[g] && filt_r[g]) begin
        if (exp_filt[g].size() == 0) begin
          stop_run($sformatf("mismatch at %0d ns: extra filtered beat dir %0d", $time, g));
        end else begin
          e = exp_filt[g].pop_front();
          compare_beat($sformatf("filt dir %0d", g), filt_d[g], e.d, filt_k[g], e.k,
                       filt_l[g], e.l);
        end
      end
    end
  end

  // Seeded back-pressure on the filtered ports
  always @(posedge nclk) begin
    #2;
    for (int i = 0; i < 2; i++) begin
      filt_r[i] = stall_en ? (($random(seed) & 3) != 0) : 1'b1;
    end
  end

  always @(negedge nclk) begin
    if (DUT.u_rx_props.err_count + DUT.u_tx_props.err_count != 0) begin
      stop_run("A bound assertion on the DUT ports failed");
    end
  end

  always @(posedge nclk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      stop_run($sformatf("Timeout: the run did not finish within %0d cycles", MAX_CYCLES));
    end
  end

  initial begin
    cfg_valid = 1'b0;
    cfg_data  = '0;
    cfg_now   = '0;
    stall_en  = 1'b0;
    for (int i = 0; i < 2; i++) begin
      in_d[i]   = '0;
      in_k[i]   = '0;
      in_l[i]   = 1'b0;
      in_v[i]   = 1'b0;
      pass_r[i] = 1'b1;
      filt_r[i] = 1'b1;
    end
    wait (nresetn_r);
    @(posedge nclk);
    #2;
    test_defaults();
    test_drop();
    test_trim();
    test_stall();
    test_both_dirs();
    $display("TB PASSED");
    $finish;
  end

endmodule

// File: source/axis_if.sv
`timescale 1ns/1ps

interface axis_if import sniffer_pkg::*; ();

  // Payload
  net_data_t tdata;
  net_keep_t tkeep;
  logic      tlast;

  // Handshake
  logic      tvalid;
  logic      tready;

  // Producer side
  modport source (
    output tdata,
    output tkeep,
    output tlast,
    output tvalid,
    input  tready
  );

  // Consumer side
  modport sink (
    input  tdata,
    input  tkeep,
    input  tlast,
    input  tvalid,
    output tready
  );

endinterface

// File: source/axis_reg_slice.sv
`timescale 1ns/1ps

module axis_reg_slice import sniffer_pkg::*; (
  input  logic      nclk,
  input  logic      nresetn_r,
  axis_if.sink      s_axis,
  // Registered output stream
  output net_data_t m_tdata,
  output net_keep_t m_tkeep,
  output logic      m_tlast,
  output logic      m_tvalid,
  input  logic      m_tready
);

  // Second entry, filled while the output is stalled
  net_data_t skid_tdata;
  net_keep_t skid_tkeep;
  logic      skid_tlast;
  logic      skid_valid;
  logic      s_acc;
  logic      m_free;

  // Ready from registered occupancy only
  assign s_axis.tready = ~skid_valid;
  assign s_acc         = s_axis.tvalid & s_axis.tready;

  // Output register can take a new beat
  assign m_free = m_tready | ~m_tvalid;

  // Occupancy
  always_ff @(posedge nclk) begin
    if (!nresetn_r) begin
      m_tvalid   <= 1'b0;
      skid_valid <= 1'b0;
    end else if (m_free) begin
      // Skid drains first, input is blocked meanwhile
      m_tvalid   <= skid_valid | s_acc;
      skid_valid <= 1'b0;
    end else if (s_acc) begin
      skid_valid <= 1'b1;
    end
  end

  // Payload
  always_ff @(posedge nclk) begin
    if (m_free) begin
      if (skid_valid) begin
        m_tdata <= skid_tdata;
        m_tkeep <= skid_tkeep;
        m_tlast <= skid_tlast;
      end else begin
        m_tdata <= s_axis.tdata;
        m_tkeep <= s_axis.tkeep;
        m_tlast <= s_axis.tlast;
      end
    end
    // Park the beat behind a stalled output
    if (!m_free && s_acc) begin
      skid_tdata <= s_axis.tdata;
      skid_tkeep <= s_axis.tkeep;
      skid_tlast <= s_axis.tlast;
    end
  end

endmodule

// File: source/packet_classifier.sv
`timescale 1ns/1ps
`include "sniffer_settings.svh"

module packet_classifier import sniffer_pkg::*; (
  input  net_data_t  data,
  output pkt_class_e pkt_class
);

  // Ethertype, big endian on the wire
  logic [15:0] eth_type;
  // IPv4 protocol number
  logic [7:0]  ip_proto;
  logic        is_ipv4;
  logic        is_ipv6;
  logic        is_arp;

  // High byte first
  assign eth_type = {data[`ETH_TYPE_BYTE*8 +: 8], data[(`ETH_TYPE_BYTE+1)*8 +: 8]};

  // Fixed offset, IHL is not looked at
  assign ip_proto = data[`IP_PROTO_BYTE*8 +: 8];

  // Ethertype decode
  assign is_ipv4 = (eth_type == `ETH_TYPE_IPV4);
  assign is_ipv6 = (eth_type == `ETH_TYPE_IPV6);
  assign is_arp  = (eth_type == `ETH_TYPE_ARP);

  always_comb begin
    // Unknown ethertypes stay in the other class
    pkt_class = PKT_OTHER;
    if (is_arp) begin
      pkt_class = PKT_ARP;
    end else if (is_ipv6) begin
      pkt_class = PKT_IPV6;
    end else if (is_ipv4) begin
      // Transport over IPv4
      case (ip_proto)
        `IP_PROTO_UDP: begin
          pkt_class = PKT_UDP4;
        end
        `IP_PROTO_TCP: begin
          pkt_class = PKT_TCP4;
        end
        default: begin
          // ICMP and the rest count as plain IPv4
          pkt_class = PKT_IPV4;
        end
      endcase
    end
  end

endmodule

// File: source/packet_filter.sv
`timescale 1ns/1ps
`include "sniffer_settings.svh"

module packet_filter import sniffer_pkg::*; (
  input  logic        nclk,
  input  logic        nresetn_r,
  input  filter_cfg_t cfg,
  // Input stream
  input  net_data_t   in_tdata,
  input  net_keep_t   in_tkeep,
  input  logic        in_tlast,
  input  logic        in_tvalid,
  output logic        in_tready,
  // Unfiltered copy
  output net_data_t   pass_tdata,
  output net_keep_t   pass_tkeep,
  output logic        pass_tlast,
  output logic        pass_tvalid,
  input  logic        pass_tready,
  // Filtered copy, into the register slice
  axis_if.source      filt
);

  // Low-lane keep masks for trimmed headers
  localparam net_keep_t KEEP_UDP4 =
    {{(`NET_KEEP_BITS-`HDR_LEN_UDP4){1'b0}}, {`HDR_LEN_UDP4{1'b1}}};
  localparam net_keep_t KEEP_TCP4 =
    {{(`NET_KEEP_BITS-`HDR_LEN_TCP4){1'b0}}, {`HDR_LEN_TCP4{1'b1}}};

  pkt_class_e     pkt_class;
  filter_action_e action;
  pkt_state_e     state;
  logic           beat_acc;
  logic           drop_hit;
  logic           trim_hit;
  logic           trimming;
  logic           keep_beat;
  net_keep_t      trim_keep;

  // Both consumers must take the beat
  assign in_tready = pass_tready & filt.tready;
  assign beat_acc  = in_tvalid & in_tready;

  // Pass path, no register
  assign pass_tvalid = in_tvalid & in_tready;
  assign pass_tdata  = in_tdata;
  assign pass_tkeep  = in_tkeep;
  assign pass_tlast  = in_tlast;

  // Only meaningful on a first beat
  packet_classifier u_classifier (
    .data      (in_tdata),
    .pkt_class (pkt_class)
  );

  // Config hits per class
  always_comb begin
    drop_hit  = 1'b0;
    trim_hit  = 1'b0;
    trim_keep = KEEP_TCP4;
    case (pkt_class)
      PKT_ARP: begin
        drop_hit = cfg[`CFG_DROP_ARP];
      end
      PKT_IPV4: begin
        drop_hit = cfg[`CFG_DROP_IPV4];
      end
      PKT_UDP4: begin
        // IPv4 family bit covers UDP too
        drop_hit  = cfg[`CFG_DROP_IPV4] | cfg[`CFG_DROP_UDP4];
        trim_hit  = cfg[`CFG_TRIM_UDP4];
        trim_keep = KEEP_UDP4;
      end
      PKT_TCP4: begin
        drop_hit  = cfg[`CFG_DROP_IPV4] | cfg[`CFG_DROP_TCP4];
        trim_hit  = cfg[`CFG_TRIM_TCP4];
        trim_keep = KEEP_TCP4;
      end
      PKT_IPV6: begin
        drop_hit = cfg[`CFG_DROP_IPV6];
      end
      default: begin
        drop_hit = 1'b0;
      end
    endcase
  end

  // Drop wins over trim
  always_comb begin
    if (drop_hit) begin
      action = ACT_DROP;
    end else if (trim_hit) begin
      action = ACT_TRIM;
    end else begin
      action = ACT_FORWARD;
    end
  end

  // Which beats reach the slice
  always_comb begin
    case (state)
      ST_FIRST: begin
        keep_beat = (action != ACT_DROP);
      end
      ST_FORWARD: begin
        keep_beat = 1'b1;
      end
      default: begin
        keep_beat = 1'b0;
      end
    endcase
  end

  assign trimming = (state == ST_FIRST) && (action == ACT_TRIM);

  // Offered only on an accepted beat, so a stall never repeats it
  assign filt.tvalid = beat_acc & keep_beat;
  assign filt.tdata  = in_tdata;
  assign filt.tkeep  = trimming ? trim_keep : in_tkeep;
  // Trimmed packet ends on its first beat
  assign filt.tlast  = trimming | in_tlast;

  // Per-packet position
  always_ff @(posedge nclk) begin
    if (!nresetn_r) begin
      state <= ST_FIRST;
    end else if (beat_acc) begin
      if (in_tlast) begin
        state <= ST_FIRST;
      end else if (state == ST_FIRST) begin
        // Drop and trim both discard the rest
        state <= (action == ACT_FORWARD) ? ST_FORWARD : ST_DISCARD;
      end
    end
  end

endmodule

// File: source/packet_sniffer.sv
`timescale 1ns/1ps

module packet_sniffer import sniffer_pkg::*; (
  input  logic        nclk,
  input  logic        nresetn_r,
  // Config word, taken whenever valid
  input  logic        cfg_valid,
  input  filter_cfg_t cfg_data,
  // RX input
  input  net_data_t   rx_tdata,
  input  net_keep_t   rx_tkeep,
  input  logic        rx_tlast,
  input  logic        rx_tvalid,
  output logic        rx_tready,
  // RX pass
  output net_data_t   rx_pass_tdata,
  output net_keep_t   rx_pass_tkeep,
  output logic        rx_pass_tlast,
  output logic        rx_pass_tvalid,
  input  logic        rx_pass_tready,
  // RX filtered
  output net_data_t   rx_filt_tdata,
  output net_keep_t   rx_filt_tkeep,
  output logic        rx_filt_tlast,
  output logic        rx_filt_tvalid,
  input  logic        rx_filt_tready,
  // TX input
  input  net_data_t   tx_tdata,
  input  net_keep_t   tx_tkeep,
  input  logic        tx_tlast,
  input  logic        tx_tvalid,
  output logic        tx_tready,
  // TX pass
  output net_data_t   tx_pass_tdata,
  output net_keep_t   tx_pass_tkeep,
  output logic        tx_pass_tlast,
  output logic        tx_pass_tvalid,
  input  logic        tx_pass_tready,
  // TX filtered
  output net_data_t   tx_filt_tdata,
  output net_keep_t   tx_filt_tkeep,
  output logic        tx_filt_tlast,
  output logic        tx_filt_tvalid,
  input  logic        tx_filt_tready
);

  // Shared by both directions
  filter_cfg_t cfg_r;

  // Filter to slice links
  axis_if rx_filt_if ();
  axis_if tx_filt_if ();

  // Zero after reset, forward everything
  always_ff @(posedge nclk) begin
    if (!nresetn_r) begin
      cfg_r <= '0;
    end else if (cfg_valid) begin
      cfg_r <= cfg_data;
    end
  end

  // RX direction
  packet_filter u_rx_filter (
    .nclk        (nclk),
    .nresetn_r   (nresetn_r),
    .cfg         (cfg_r),
    .in_tdata    (rx_tdata),
    .in_tkeep    (rx_tkeep),
    .in_tlast    (rx_tlast),
    .in_tvalid   (rx_tvalid),
    .in_tready   (rx_tready),
    .pass_tdata  (rx_pass_tdata),
    .pass_tkeep  (rx_pass_tkeep),
    .pass_tlast  (rx_pass_tlast),
    .pass_tvalid (rx_pass_tvalid),
    .pass_tready (rx_pass_tready),
    .filt        (rx_filt_if)
  );

  axis_reg_slice u_rx_slice (
    .nclk      (nclk),
    .nresetn_r (nresetn_r),
    .s_axis    (rx_filt_if),
    .m_tdata   (rx_filt_tdata),
    .m_tkeep   (rx_filt_tkeep),
    .m_tlast   (rx_filt_tlast),
    .m_tvalid  (rx_filt_tvalid),
    .m_tready  (rx_filt_tready)
  );

  // TX direction
  packet_filter u_tx_filter (
    .nclk        (nclk),
    .nresetn_r   (nresetn_r),
    .cfg         (cfg_r),
    .in_tdata    (tx_tdata),
    .in_tkeep    (tx_tkeep),
    .in_tlast    (tx_tlast),
    .in_tvalid   (tx_tvalid),
    .in_tready   (tx_tready),
    .pass_tdata  (tx_pass_tdata),
    .pass_tkeep  (tx_pass_tkeep),
    .pass_tlast  (tx_pass_tlast),
    .pass_tvalid (tx_pass_tvalid),
    .pass_tready (tx_pass_tready),
    .filt        (tx_filt_if)
  );

  axis_reg_slice u_tx_slice (
    .nclk      (nclk),
    .nresetn_r (nresetn_r),
    .s_axis    (tx_filt_if),
    .m_tdata   (tx_filt_tdata),
    .m_tkeep   (tx_filt_tkeep),
    .m_tlast   (tx_filt_tlast),
    .m_tvalid  (tx_filt_tvalid),
    .m_tready  (tx_filt_tready)
  );

endmodule

// File: source/sniffer_pkg.sv
`include "sniffer_settings.svh"

package sniffer_pkg;

  // Stream payload
  typedef logic [`NET_DATA_BITS-1:0] net_data_t;
  typedef logic [`NET_KEEP_BITS-1:0] net_keep_t;

  // Filter configuration word
  typedef logic [`CFG_BITS-1:0] filter_cfg_t;

  // Class of a packet, taken from its first beat
  typedef enum logic [2:0] {
    PKT_OTHER,
    PKT_ARP,
    PKT_IPV4,
    PKT_UDP4,
    PKT_TCP4,
    PKT_IPV6
  } pkt_class_e;

  // What happens to a packet on the filtered path
  typedef enum logic [1:0] {
    ACT_FORWARD,
    ACT_DROP,
    ACT_TRIM
  } filter_action_e;

  // Position within a packet, per direction
  // Discard also covers the tail of a trimmed packet
  typedef enum logic [1:0] {
    ST_FIRST,
    ST_FORWARD,
    ST_DISCARD
  } pkt_state_e;

endpackage

// File: source/sniffer_settings.svh
`ifndef SNIFFER_SETTINGS_SVH
`define SNIFFER_SETTINGS_SVH

// Stream bus geometry
// 512-bit data in 64 byte lanes
`define NET_DATA_BITS 512
`define NET_KEEP_BITS 64

// Configuration word
`define CFG_BITS 64

// Config bit positions
// Drop every IPv4 packet, UDP and TCP included
`define CFG_DROP_IPV4 8
`define CFG_DROP_IPV6 9
`define CFG_DROP_ARP  16
// UDP over IPv4
`define CFG_DROP_UDP4 22
`define CFG_TRIM_UDP4 23
// TCP over IPv4
`define CFG_DROP_TCP4 26
`define CFG_TRIM_TCP4 27

// Ethertypes as they appear on the wire
`define ETH_TYPE_IPV4 16'h0800
`define ETH_TYPE_IPV6 16'h86dd
`define ETH_TYPE_ARP  16'h0806

// Byte offset of the ethertype high byte
// Low byte follows at the next offset
`define ETH_TYPE_BYTE (12)

// Protocol field, 14-byte MAC header plus offset 9 of IPv4 header
// Only right for a 20-byte IPv4 header
`define IP_PROTO_BYTE (23)

// IP protocol numbers
`define IP_PROTO_UDP 8'h11
`define IP_PROTO_TCP 8'h06

// Trimmed lengths in bytes
// 14 MAC + 20 IPv4 + 8 UDP
`define HDR_LEN_UDP4 42
// 14 MAC + 20 IPv4 + 20 TCP, options cut off
`define HDR_LEN_TCP4 54

`endif
